/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Base instruction word, field order as in the R-type layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_instr_t;

  // Base opcodes
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // Base funct3 values
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_lw      = 3'b010;
  localparam logic [2:0] f3_sw      = 3'b010;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;

  // Base funct7 values, alt selects sub and sra
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // Compressed quadrants
  localparam logic [1:0] q0     = 2'b00;
  localparam logic [1:0] q1     = 2'b01;
  localparam logic [1:0] q2     = 2'b10;
  localparam logic [1:0] q_base = 2'b11;

  // Quadrant 0 groups
  localparam logic [2:0] c_f3_lw = 3'b010;
  localparam logic [2:0] c_f3_sw = 3'b110;

  // Quadrant 1 groups
  localparam logic [2:0] c_f3_addi     = 3'b000;
  localparam logic [2:0] c_f3_li       = 3'b010;
  localparam logic [2:0] c_f3_lui      = 3'b011;
  localparam logic [2:0] c_f3_misc_alu = 3'b100;
  localparam logic [2:0] c_f3_beqz     = 3'b110;
  localparam logic [2:0] c_f3_bnez     = 3'b111;

  // Quadrant 2 groups
  localparam logic [2:0] c_f3_slli   = 3'b000;
  localparam logic [2:0] c_f3_mv_add = 3'b100;

  // Sub-selects inside the misc ALU group, parcel bits 11:10
  localparam logic [1:0] c_alu_srli = 2'b00;
  localparam logic [1:0] c_alu_srai = 2'b01;
  localparam logic [1:0] c_alu_andi = 2'b10;
  localparam logic [1:0] c_alu_reg  = 2'b11;

  // Register-register ops, parcel bits 6:5
  localparam logic [1:0] c_reg_sub = 2'b00;
  localparam logic [1:0] c_reg_xor = 2'b01;
  localparam logic [1:0] c_reg_or  = 2'b10;
  localparam logic [1:0] c_reg_and = 2'b11;

endpackage

/* hdl/fetch_pkg.sv */
package fetch_pkg;

  // One fetch word per strobe
  localparam int fetch_width = 32;

  // Compressed parcel size
  localparam int parcel_width = 16;

  // Parcels per fetch word
  localparam int num_lanes = fetch_width / parcel_width;

  // Instructions emitted per fetch word at most
  localparam int num_slots = 2;

endpackage

/* hdl/rvc_expander.sv */
`timescale 1ns/100ps

module rvc_expander
  import rv_isa_pkg::*;
(
  input  logic [15:0] parcel,
  output logic        is_compressed,
  output rv_instr_t   expanded,
  output logic        illegal
);

  logic [1:0]  quadrant;
  logic [2:0]  c_funct3;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rd_short;
  logic [4:0]  rs2_short;
  logic [4:0]  shamt;
  logic        shamt_hi;
  logic [11:0] imm6_sext;
  logic [19:0] lui_imm;
  logic [11:0] mem_offset;
  logic [12:0] br_offset;

  function automatic rv_instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    r_type = {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv_instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    i_type = {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_instr_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [6:0] op);
    s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic rv_instr_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [6:0] op);
    b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic rv_instr_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    u_type = {imm, rd, op};
  endfunction

  assign quadrant = parcel[1:0];
  assign c_funct3 = parcel[15:13];
  assign rd_full  = parcel[11:7];
  assign rs2_full = parcel[6:2];

  // Short register fields select x8 to x15
  assign rd_short  = {2'b01, parcel[9:7]};
  assign rs2_short = {2'b01, parcel[4:2]};

  // Bit 5 of a shift amount must be zero on RV32
  assign shamt    = parcel[6:2];
  assign shamt_hi = parcel[12];

  assign imm6_sext  = {{6{parcel[12]}}, parcel[12], parcel[6:2]};
  assign lui_imm    = {{14{parcel[12]}}, parcel[12], parcel[6:2]};
  assign mem_offset = {5'b00000, parcel[5], parcel[12:10], parcel[6], 2'b00};
  assign br_offset  = {{5{parcel[12]}}, parcel[6:5], parcel[2], parcel[11:10],
                       parcel[4:3], 1'b0};

  assign is_compressed = (quadrant != q_base);

  always_comb begin
    expanded = '0;
    illegal  = 1'b0;
    case (quadrant)
      q0: begin
        case (c_funct3)
          c_f3_lw: expanded = i_type(mem_offset, rd_short, f3_lw, rs2_short, op_load);
          c_f3_sw: expanded = s_type(mem_offset, rs2_short, rd_short, f3_sw, op_store);
          default: illegal = 1'b1;
        endcase
      end
      q1: begin
        case (c_funct3)
          c_f3_addi: expanded = i_type(imm6_sext, rd_full, f3_add_sub, rd_full, op_op_imm);
          c_f3_li:   expanded = i_type(imm6_sext, 5'd0, f3_add_sub, rd_full, op_op_imm);
          c_f3_lui: begin
            // rd of x2 is the stack-pointer form, zero immediate is reserved
            if (rd_full == 5'd2 || imm6_sext == 12'd0) begin
              illegal = 1'b1;
            end else begin
              expanded = u_type(lui_imm, rd_full, op_lui);
            end
          end
          c_f3_misc_alu: begin
            case (parcel[11:10])
              c_alu_srli: begin
                if (shamt_hi) begin
                  illegal = 1'b1;
                end else begin
                  expanded = r_type(f7_base, shamt, rd_short, f3_srl_sra, rd_short, op_op_imm);
                end
              end
              c_alu_srai: begin
                if (shamt_hi) begin
                  illegal = 1'b1;
                end else begin
                  expanded = r_type(f7_alt, shamt, rd_short, f3_srl_sra, rd_short, op_op_imm);
                end
              end
              c_alu_andi: begin
                expanded = i_type(imm6_sext, rd_short, f3_and, rd_short, op_op_imm);
              end
              c_alu_reg: begin
                // Bit 12 set selects the RV64 word forms
                if (parcel[12]) begin
                  illegal = 1'b1;
                end else begin
                  case (parcel[6:5])
                    c_reg_sub: expanded = r_type(f7_alt, rs2_short, rd_short, f3_add_sub,
                                                 rd_short, op_op);
                    c_reg_xor: expanded = r_type(f7_base, rs2_short, rd_short, f3_xor,
                                                 rd_short, op_op);
                    c_reg_or:  expanded = r_type(f7_base, rs2_short, rd_short, f3_or,
                                                 rd_short, op_op);
                    c_reg_and: expanded = r_type(f7_base, rs2_short, rd_short, f3_and,
                                                 rd_short, op_op);
                    default:   illegal = 1'b1;
                  endcase
                end
              end
              default: illegal = 1'b1;
            endcase
          end
          c_f3_beqz: expanded = b_type(br_offset, 5'd0, rd_short, f3_beq, op_branch);
          c_f3_bnez: expanded = b_type(br_offset, 5'd0, rd_short, f3_bne, op_branch);
          default:   illegal = 1'b1;
        endcase
      end
      q2: begin
        case (c_funct3)
          c_f3_slli: begin
            if (shamt_hi) begin
              illegal = 1'b1;
            end else begin
              expanded = r_type(f7_base, shamt, rd_full, f3_sll, rd_full, op_op_imm);
            end
          end
          c_f3_mv_add: begin
            // rs2 of x0 encodes jumps and ebreak
            if (rs2_full == 5'd0) begin
              illegal = 1'b1;
            end else if (parcel[12]) begin
              expanded = r_type(f7_base, rs2_full, rd_full, f3_add_sub, rd_full, op_op);
            end else begin
              expanded = r_type(f7_base, rs2_full, 5'd0, f3_add_sub, rd_full, op_op);
            end
          end
          default: illegal = 1'b1;
        endcase
      end
      default: begin
        // Full-width parcel, nothing to expand
        illegal = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/parcel_packer.sv */
`timescale 1ns/100ps

module parcel_packer
  import rv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  logic [fetch_width-1:0] fetch_word,
  input  logic                   redirect,
  input  logic                   lane0_compressed,
  input  rv_instr_t              lane0_expanded,
  input  logic                   lane0_illegal,
  input  logic                   lane1_compressed,
  input  rv_instr_t              lane1_expanded,
  input  logic                   lane1_illegal,
  output logic                   slot0_valid,
  output rv_instr_t              slot0_instr,
  output logic                   slot0_illegal,
  output logic                   slot1_valid,
  output rv_instr_t              slot1_instr,
  output logic                   slot1_illegal
);

  logic [num_lanes-1:0]    lane_compressed;
  logic [num_lanes-1:0]    lane_illegal;
  rv_instr_t               lane_expanded [num_lanes];

  logic                    held_q;
  logic                    held_d;
  logic                    held_live;
  logic [parcel_width-1:0] held_parcel_q;
  logic [parcel_width-1:0] held_parcel_d;
  logic                    lane1_free;

  logic [num_slots-1:0]    slot_valid_d;
  logic [num_slots-1:0]    slot_valid_q;
  logic [num_slots-1:0]    slot_illegal_d;
  logic [num_slots-1:0]    slot_illegal_q;
  rv_instr_t               slot_instr_d [num_slots];
  rv_instr_t               slot_instr_q [num_slots];

  assign lane_compressed  = {lane1_compressed, lane0_compressed};
  assign lane_illegal     = {lane1_illegal, lane0_illegal};
  assign lane_expanded[0] = lane0_expanded;
  assign lane_expanded[1] = lane1_expanded;

  // A redirect in the same cycle lands ahead of the fetch
  assign held_live = held_q & ~redirect;

  always_comb begin
    slot_valid_d    = '0;
    slot_illegal_d  = '0;
    slot_instr_d[0] = '0;
    slot_instr_d[1] = '0;
    held_d          = held_live;
    held_parcel_d   = held_parcel_q;
    lane1_free      = 1'b0;
    if (fetch_valid) begin
      slot_valid_d[0] = 1'b1;
      held_d          = 1'b0;
      lane1_free      = 1'b1;
      if (held_live) begin
        // Held parcel is the low half, lane 0 completes it
        slot_instr_d[0] = rv_instr_t'({fetch_word[parcel_width-1:0], held_parcel_q});
      end else if (lane_compressed[0]) begin
        slot_instr_d[0]   = lane_expanded[0];
        slot_illegal_d[0] = lane_illegal[0];
      end else begin
        slot_instr_d[0] = rv_instr_t'(fetch_word);
        lane1_free      = 1'b0;
      end
      if (lane1_free) begin
        if (lane_compressed[1]) begin
          slot_valid_d[1]   = 1'b1;
          slot_instr_d[1]   = lane_expanded[1];
          slot_illegal_d[1] = lane_illegal[1];
        end else begin
          held_d        = 1'b1;
          held_parcel_d = fetch_word[fetch_width-1:parcel_width];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid_q   <= '0;
      slot_illegal_q <= '0;
      held_q         <= 1'b0;
    end else begin
      slot_valid_q   <= slot_valid_d;
      slot_illegal_q <= slot_illegal_d;
      held_q         <= held_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_instr_q  <= slot_instr_d;
    held_parcel_q <= held_parcel_d;
  end

  assign slot0_valid   = slot_valid_q[0];
  assign slot0_instr   = slot_instr_q[0];
  assign slot0_illegal = slot_illegal_q[0];
  assign slot1_valid   = slot_valid_q[1];
  assign slot1_instr   = slot_instr_q[1];
  assign slot1_illegal = slot_illegal_q[1];

endmodule

/* hdl/fetch_realign_top.sv */
`timescale 1ns/100ps

module fetch_realign_top
  import rv_isa_pkg::*;
  import fetch_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  logic [fetch_width-1:0] fetch_word,
  input  logic                   redirect,
  output logic                   slot0_valid,
  output rv_instr_t              slot0_instr,
  output logic                   slot0_illegal,
  output logic                   slot1_valid,
  output rv_instr_t              slot1_instr,
  output logic                   slot1_illegal
);

  logic      lane0_compressed;
  rv_instr_t lane0_expanded;
  logic      lane0_illegal;
  logic      lane1_compressed;
  rv_instr_t lane1_expanded;
  logic      lane1_illegal;

  // Lane 0 is the lower parcel of the fetch word
  rvc_expander u_lane0_expander (
    .parcel        (fetch_word[parcel_width-1:0]),
    .is_compressed (lane0_compressed),
    .expanded      (lane0_expanded),
    .illegal       (lane0_illegal)
  );

  rvc_expander u_lane1_expander (
    .parcel        (fetch_word[fetch_width-1:parcel_width]),
    .is_compressed (lane1_compressed),
    .expanded      (lane1_expanded),
    .illegal       (lane1_illegal)
  );

  parcel_packer u_packer (
    .clk              (clk),
    .reset            (reset),
    .fetch_valid      (fetch_valid),
    .fetch_word       (fetch_word),
    .redirect         (redirect),
    .lane0_compressed (lane0_compressed),
    .lane0_expanded   (lane0_expanded),
    .lane0_illegal    (lane0_illegal),
    .lane1_compressed (lane1_compressed),
    .lane1_expanded   (lane1_expanded),
    .lane1_illegal    (lane1_illegal),
    .slot0_valid      (slot0_valid),
    .slot0_instr      (slot0_instr),
    .slot0_illegal    (slot0_illegal),
    .slot1_valid      (slot1_valid),
    .slot1_instr      (slot1_instr),
    .slot1_illegal    (slot1_illegal)
  );

endmodule

/* verif/tb_rvc_model.svh */
// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Returns {illegal, base instruction}, all zero for a full-width parcel
function automatic logic [32:0] ref_expand(input logic [15:0] p);
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdc;
  logic [4:0]  rs2c;
  logic [11:0] simm;
  logic [11:0] mimm;
  logic [12:0] bimm;
  logic [2:0]  alu_f3;
  logic [31:0] ins;
  logic        bad;
  rd     = p[11:7];
  rs2    = p[6:2];
  rdc    = 5'd8 + p[9:7];
  rs2c   = 5'd8 + p[4:2];
  simm   = {{7{p[12]}}, p[6:2]};
  mimm   = {5'd0, p[5], p[12:10], p[6], 2'd0};
  bimm   = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
  alu_f3 = (p[6:5] == 2'b00) ? 3'b000 : {1'b1, p[6], p[6] & p[5]};
  ins    = '0;
  bad    = 1'b0;
  case ({p[1:0], p[15:13]})
    5'b00_010: ins = {mimm, rdc, 3'b010, rs2c, 7'h03};
    5'b00_110: ins = {mimm[11:5], rs2c, rdc, 3'b010, mimm[4:0], 7'h23};
    5'b01_000: ins = {simm, rd, 3'b000, rd, 7'h13};
    5'b01_010: ins = {simm, 5'd0, 3'b000, rd, 7'h13};
    5'b01_011: begin
      ins = {{8{p[12]}}, simm, rd, 7'h37};
      bad = (rd == 5'd2) || (simm == 12'd0);
    end
    5'b01_100: begin
      case (p[11:10])
        2'b00:   ins = {7'h00, rs2, rdc, 3'b101, rdc, 7'h13};
        2'b01:   ins = {7'h20, rs2, rdc, 3'b101, rdc, 7'h13};
        2'b10:   ins = {simm, rdc, 3'b111, rdc, 7'h13};
        default: ins = {(p[6:5] == 2'b00) ? 7'h20 : 7'h00, rs2c, rdc, alu_f3, rdc, 7'h33};
      endcase
      // Shift amount bit 5 and the word forms are reserved on RV32
      bad = p[12] && (p[11:10] != 2'b10);
    end
    5'b01_110: ins = {bimm[12], bimm[10:5], 5'd0, rdc, 3'b000, bimm[4:1], bimm[11], 7'h63};
    5'b01_111: ins = {bimm[12], bimm[10:5], 5'd0, rdc, 3'b001, bimm[4:1], bimm[11], 7'h63};
    5'b10_000: begin
      ins = {7'h00, rs2, rd, 3'b001, rd, 7'h13};
      bad = p[12];
    end
    5'b10_100: begin
      ins = {7'h00, rs2, p[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
      bad = (rs2 == 5'd0);
    end
    default: bad = (p[1:0] != 2'b11);
  endcase
  ref_expand = bad ? {1'b1, 32'd0} : {1'b0, ins};
endfunction

// Result is {held, held parcel, v0, ill0, instr0, v1, ill1, instr1}
function automatic logic [84:0] ref_pack(input logic held, input logic [15:0] hp,
                                         input logic [31:0] w);
  logic [32:0] lo;
  logic [32:0] hi;
  logic [67:0] s;
  logic        h;
  logic [15:0] p;
  logic        take_hi;
  lo      = ref_expand(w[15:0]);
  hi      = ref_expand(w[31:16]);
  s       = '0;
  h       = 1'b0;
  p       = hp;
  take_hi = 1'b1;
  s[67]   = 1'b1;
  if (held) begin
    s[65:34] = {w[15:0], hp};
  end else if (w[1:0] != 2'b11) begin
    s[66:34] = lo;
  end else begin
    s[65:34] = w;
    take_hi  = 1'b0;
  end
  if (take_hi && w[17:16] != 2'b11) begin
    s[33:0] = {1'b1, hi};
  end else if (take_hi) begin
    h = 1'b1;
    p = w[31:16];
  end
  ref_pack = {h, p, s};
endfunction

/* verif/tb_fetch_realign.sv */
`timescale 1ns/100ps

module tb_fetch_realign
  import fetch_pkg::*;
();

  localparam int period        = 40;
  localparam int reset_cycles  = 8;
  localparam int num_fetches   = 400;
  localparam int num_templates = 22;

  // Mask in the upper half, fixed bits in the lower half, full-width parcel last
  localparam logic [num_templates*32-1:0] templates = {
    32'hE003_4000, 32'hE003_C000, 32'hE003_0001, 32'hE003_4001, 32'hE003_6001,
    32'hFC03_8001, 32'hFC03_8401, 32'hEC03_8801, 32'hFC63_8C01, 32'hFC63_8C21,
    32'hFC63_8C41, 32'hFC63_8C61, 32'hE003_C001, 32'hE003_E001, 32'hF003_0002,
    32'hF003_8002, 32'hF003_9002, 32'hE003_0000, 32'hE003_2001, 32'hE003_4002,
    32'hE003_A001, 32'h0003_0003
  };

  logic                   clk;
  logic                   reset;
  logic                   fetch_valid;
  logic [fetch_width-1:0] fetch_word;
  logic                   redirect;
  logic                   slot0_valid;
  logic [31:0]            slot0_instr;
  logic                   slot0_illegal;
  logic                   slot1_valid;
  logic [31:0]            slot1_instr;
  logic                   slot1_illegal;

  logic [15:0] lfsr_state;
  logic [15:0] lane0_parcel;
  logic [15:0] lane1_parcel;
  logic [2:0]  mode;
  logic        model_held;
  logic [15:0] model_parcel;
  logic [84:0] step;
  logic [67:0] exp_slots;
  logic [67:0] expected_q [$];
  int          errors = 0;
  int          checks = 0;

  fetch_realign_top u_fetch_realign_top (
    .clk           (clk),
    .reset         (reset),
    .fetch_valid   (fetch_valid),
    .fetch_word    (fetch_word),
    .redirect      (redirect),
    .slot0_valid   (slot0_valid),
    .slot0_instr   (slot0_instr),
    .slot0_illegal (slot0_illegal),
    .slot1_valid   (slot1_valid),
    .slot1_instr   (slot1_instr),
    .slot1_illegal (slot1_illegal)
  );

  `include "tb_rvc_model.svh"

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[14:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    take_bits = v;
  endfunction

  function automatic logic [15:0] make_parcel();
    logic [15:0] k;
    logic [31:0] t;
    k = take_bits(5);
    k = (k >= num_templates) ? num_templates - 1 : k;
    t = templates[(num_templates - 1 - k) * 32 +: 32];
    make_parcel = (take_bits(16) & ~t[31:16]) | t[15:0];
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic [31:0] word, input logic redir);
    @(posedge clk);
    fetch_valid <= valid;
    fetch_word  <= word;
    redirect    <= redir;
  endtask

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    reset       = 1'b1;
    fetch_valid = 1'b0;
    fetch_word  = '0;
    redirect    = 1'b0;
    lfsr_state  = 16'd16;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    repeat (num_fetches) begin
      if (take_bits(2) == 0) begin
        drive_cycle(1'b0, '0, 1'b0);
      end
      mode = take_bits(3);
      // Mode 0 redirects alone, mode 1 together with the fetch
      if (mode == 0) begin
        drive_cycle(1'b0, '0, 1'b1);
      end
      lane0_parcel = make_parcel();
      lane1_parcel = make_parcel();
      drive_cycle(1'b1, {lane1_parcel, lane0_parcel}, mode == 1);
    end
    repeat (3) drive_cycle(1'b0, '0, 1'b0);
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Outputs and inputs are both settled at the falling edge
  always @(negedge clk) begin
    if (expected_q.size() > 0) begin
      exp_slots = expected_q.pop_front();
      if (slot0_valid !== exp_slots[67]) begin
        errors = errors + 1;
        $display("Slot 0 strobe %s at %0t ns", exp_slots[67] ? "missing" : "unexpected", $time);
      end else if (exp_slots[67]) begin
        compare("slot0_instr", exp_slots[65:34], slot0_instr);
        compare("slot0_illegal", exp_slots[66], slot0_illegal);
      end
      if (slot1_valid !== exp_slots[33]) begin
        errors = errors + 1;
        $display("Slot 1 strobe %s at %0t ns", exp_slots[33] ? "missing" : "unexpected", $time);
      end else if (exp_slots[33]) begin
        compare("slot1_instr", exp_slots[31:0], slot1_instr);
        compare("slot1_illegal", exp_slots[32], slot1_illegal);
      end
    end
    if (reset) begin
      model_held = 1'b0;
      expected_q.push_back('0);
    end else if (fetch_valid) begin
      step         = ref_pack(model_held && !redirect, model_parcel, fetch_word);
      model_held   = step[84];
      model_parcel = step[83:68];
      expected_q.push_back(step[67:0]);
    end else begin
      model_held = model_held && !redirect;
      expected_q.push_back('0);
    end
  end

  initial begin
    #((num_fetches * 3 + reset_cycles + 10) * period);
    $display("Watchdog expired before the fetch sequence completed");
    $display("sim failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+verif
hdl/rv_isa_pkg.sv
hdl/fetch_pkg.sv
hdl/rvc_expander.sv
hdl/parcel_packer.sv
hdl/fetch_realign_top.sv
verif/tb_fetch_realign.sv

/* Bender.yml */
package:
  name: fetch_realign

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/fetch_pkg.sv
  - hdl/rvc_expander.sv
  - hdl/parcel_packer.sv
  - hdl/fetch_realign_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_fetch_realign.sv
